// File: project.f
+incdir+src
src/sb_pkg.sv
src/sb_issue_if.sv
src/sb_slot_tracker.sv
src/sb_mul_tracker.sv
src/sb_div_fsm.sv
src/sb_issue_ctrl.sv
src/sb_top.sv
dv/sb_tb.sv

// File: Makefile
# Verilator flow for the issue scoreboard

VERILATOR ?= verilator
TOP       ?= sb_tb
RTL_TOP   ?= sb_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Regression failed
VFLAGS    ?= --timing --assert

SOURCES := $(FILELIST) $(wildcard src/*.sv src/*.svh dv/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/sb_tb.sv
// Issue scoreboard testbench
// Applies a table of dispatched instructions, each row held for one or
// more cycles, and checks the issue grant and the empty flag against
// values derived by hand from the scoreboard rules

`timescale 1ns/1ps
`default_nettype none

module sb_tb import sb_pkg::*; ();

    // One-hot unit encodings
    localparam unit_sel_t U_NONE = 3'b000;
    localparam unit_sel_t U_ALU  = 3'b001;
    localparam unit_sel_t U_MUL  = 3'b010;
    localparam unit_sel_t U_DIV  = 3'b100;

    typedef struct {
        int        reps;
        unit_sel_t unit;
        reg_addr_t src_a;
        reg_addr_t src_b;
        reg_addr_t dest;
        logic      stall;
        logic      flush;
        logic      exp_issue;
        logic      exp_empty;
    } row_t;

    logic      clk_i;
    logic      rst_n_i;
    logic      flush_i;
    logic      stall_i;
    reg_addr_t src_a_i;
    reg_addr_t src_b_i;
    reg_addr_t dest_i;
    unit_sel_t unit_i;
    logic      issue_o;
    logic      pipeline_empty_o;

    row_t rows[$];
    int   total_cycles = 0;
    int   cycle_limit = 0;
    int   cycle_count = 0;
    int   error_count = 0;

    sb_top u_dut (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .stall_i          (stall_i),
        .src_a_i          (src_a_i),
        .src_b_i          (src_b_i),
        .dest_i           (dest_i),
        .unit_i           (unit_i),
        .issue_o          (issue_o),
        .pipeline_empty_o (pipeline_empty_o)
    );

    // 100 ns clock
    always #50 clk_i = ~clk_i;

    // Watchdog on the total number of cycles
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run went past %0d cycles", cycle_limit);
            $display("Regression failed");
            $fatal(1, "simulation did not finish in time");
        end
    end

    task automatic add_row(input int reps, input unit_sel_t unit, input reg_addr_t src_a,
                           input reg_addr_t src_b, input reg_addr_t dest, input logic stall,
                           input logic flush, input logic exp_issue, input logic exp_empty);
        row_t r;
        r.reps      = reps;
        r.unit      = unit;
        r.src_a     = src_a;
        r.src_b     = src_b;
        r.dest      = dest;
        r.stall     = stall;
        r.flush     = flush;
        r.exp_issue = exp_issue;
        r.exp_empty = exp_empty;
        rows.push_back(r);
        total_cycles += reps;
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch at %0t: %s, got %0d, expected %0d",
                     $time, what, actual, expected);
            $display("Regression failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic drive_row(input row_t r);
        unit_i  = r.unit;
        src_a_i = r.src_a;
        src_b_i = r.src_b;
        dest_i  = r.dest;
        stall_i = r.stall;
        flush_i = r.flush;
    endtask

    // ============================================================
    // Stimulus table: reps, unit, src_a, src_b, dest, stall, flush,
    // expected issue, expected empty
    // ============================================================
    task automatic build_table();
        // Empty after reset, ALU issues
        add_row(1, U_ALU, 5'd1, 5'd2, 5'd3, 1'b0, 1'b0, 1'b1, 1'b1);
        // MUL to x5, reader of x5 blocked while count runs 6 down to 1
        add_row(1, U_MUL, 5'd1, 5'd2, 5'd5, 1'b0, 1'b0, 1'b1, 1'b1);
        add_row(6, U_ALU, 5'd5, 5'd0, 5'd6, 1'b0, 1'b0, 1'b0, 1'b0);
        add_row(1, U_ALU, 5'd5, 5'd0, 5'd6, 1'b0, 1'b0, 1'b1, 1'b1);
        // MUL to x0 is tracked but never blocks
        add_row(1, U_MUL, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0, 1'b1, 1'b1);
        add_row(6, U_ALU, 5'd0, 5'd0, 5'd7, 1'b0, 1'b0, 1'b1, 1'b0);
        // Back to back MULs, request 7 never meets a MUL count
        add_row(1, U_MUL, 5'd1, 5'd2, 5'd8, 1'b0, 1'b0, 1'b1, 1'b1);
        add_row(1, U_MUL, 5'd1, 5'd2, 5'd9, 1'b0, 1'b0, 1'b1, 1'b0);
        add_row(3, U_ALU, 5'd1, 5'd2, 5'd4, 1'b0, 1'b0, 1'b1, 1'b0);
        // ALU request 2 collides with x8 then x9 at count 2
        add_row(2, U_ALU, 5'd1, 5'd2, 5'd4, 1'b0, 1'b0, 1'b0, 1'b0);
        add_row(1, U_MUL, 5'd1, 5'd2, 5'd10, 1'b0, 1'b0, 1'b1, 1'b0);
        // No unit selected while the last MUL drains
        add_row(6, U_NONE, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0, 1'b1, 1'b0);
        // DIV to x20, second DIV held off for 36 unstalled cycles
        add_row(1, U_DIV, 5'd1, 5'd2, 5'd20, 1'b0, 1'b0, 1'b1, 1'b1);
        add_row(5, U_DIV, 5'd3, 5'd4, 5'd21, 1'b0, 1'b0, 1'b0, 1'b0);
        add_row(1, U_ALU, 5'd1, 5'd2, 5'd12, 1'b0, 1'b0, 1'b1, 1'b0);
        add_row(23, U_DIV, 5'd3, 5'd4, 5'd21, 1'b0, 1'b0, 1'b0, 1'b0);
        // MUL request 7 against DIV count 7, then count 6
        add_row(1, U_MUL, 5'd3, 5'd4, 5'd13, 1'b0, 1'b0, 1'b0, 1'b0);
        add_row(1, U_MUL, 5'd3, 5'd4, 5'd13, 1'b0, 1'b0, 1'b1, 1'b0);
        add_row(5, U_DIV, 5'd3, 5'd4, 5'd21, 1'b0, 1'b0, 1'b0, 1'b0);
        // Divider free again, MUL to x13 still has one cycle left
        add_row(1, U_DIV, 5'd3, 5'd4, 5'd21, 1'b0, 1'b0, 1'b1, 1'b0);
        // MUL to x5 behind the second DIV, then stall freezes both
        add_row(1, U_MUL, 5'd1, 5'd2, 5'd5, 1'b0, 1'b0, 1'b1, 1'b0);
        add_row(10, U_ALU, 5'd5, 5'd0, 5'd6, 1'b1, 1'b0, 1'b0, 1'b0);
        // Flush clears every count at the next edge
        add_row(1, U_ALU, 5'd5, 5'd0, 5'd6, 1'b0, 1'b1, 1'b0, 1'b0);
        add_row(1, U_ALU, 5'd5, 5'd0, 5'd6, 1'b0, 1'b0, 1'b1, 1'b1);
        // Grant shown under stall but nothing is loaded
        add_row(2, U_MUL, 5'd1, 5'd2, 5'd5, 1'b1, 1'b0, 1'b1, 1'b1);
        add_row(1, U_ALU, 5'd5, 5'd0, 5'd6, 1'b0, 1'b0, 1'b1, 1'b1);
    endtask

    initial begin
        clk_i   = 1'b0;
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        stall_i = 1'b0;
        src_a_i = '0;
        src_b_i = '0;
        dest_i  = '0;
        unit_i  = U_NONE;

        build_table();
        cycle_limit = 2 * total_cycles + 50;

        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        // Drive on the falling edge, sample shortly before the rising edge
        foreach (rows[r]) begin
            for (int n = 0; n < rows[r].reps; n++) begin
                @(negedge clk_i);
                drive_row(rows[r]);
                #45;
                check_value(32'(issue_o), 32'(rows[r].exp_issue),
                            $sformatf("row %0d cycle %0d issue_o", r, n));
                check_value(32'(pipeline_empty_o), 32'(rows[r].exp_empty),
                            $sformatf("row %0d cycle %0d pipeline_empty_o", r, n));
            end
        end

        @(negedge clk_i);
        unit_i = U_NONE;
        if (error_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Regression failed");
            $fatal(1, "checks failed");
        end
    end

endmodule : sb_tb

`default_nettype wire

// File: src/sb_top.sv
// Issue scoreboard top level
// Blocks issue on RAW/WAW, write-back collision and divider
// structural hazards, and flags an empty execution pipeline

`timescale 1ns/1ps
`default_nettype none

module sb_top import sb_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      flush_i,
    input  logic      stall_i,
    input  reg_addr_t src_a_i,
    input  reg_addr_t src_b_i,
    input  reg_addr_t dest_i,
    input  unit_sel_t unit_i,
    output logic      issue_o,
    output logic      pipeline_empty_o
);

    logic mul_raw, mul_lat, mul_busy;
    logic div_raw, div_lat, div_struct, div_busy;

    sb_issue_if bus ();

    // Dispatched instruction onto the bus
    assign bus.src_a = src_a_i;
    assign bus.src_b = src_b_i;
    assign bus.dest  = dest_i;
    assign bus.stall = stall_i;

    sb_issue_ctrl u_ctrl (
        .unit_i (unit_i), .bus (bus),
        .mul_raw_hazard_i (mul_raw), .mul_lat_hazard_i (mul_lat), .mul_busy_i (mul_busy),
        .div_raw_hazard_i (div_raw), .div_lat_hazard_i (div_lat),
        .div_struct_hazard_i (div_struct), .div_busy_i (div_busy),
        .issue_o (issue_o), .pipeline_empty_o (pipeline_empty_o)
    );

    sb_mul_tracker u_mul (
        .clk_i (clk_i), .rst_n_i (rst_n_i), .flush_i (flush_i),
        .mul_req_i (unit_i[UNIT_MUL]), .bus (bus),
        .raw_hazard_o (mul_raw), .lat_hazard_o (mul_lat), .busy_o (mul_busy)
    );

    sb_div_fsm u_div (
        .clk_i (clk_i), .rst_n_i (rst_n_i), .flush_i (flush_i),
        .div_req_i (unit_i[UNIT_DIV]), .bus (bus),
        .raw_hazard_o (div_raw), .lat_hazard_o (div_lat),
        .struct_hazard_o (div_struct), .busy_o (div_busy)
    );

endmodule : sb_top

`default_nettype wire

// File: src/sb_issue_ctrl.sv
// Issue control
// Decodes the requested write-back latency of the dispatched unit and
// merges all tracker hazards into the issue grant and empty flag

`timescale 1ns/1ps
`default_nettype none

`include "sb_config.svh"

module sb_issue_ctrl import sb_pkg::*; (
    input  unit_sel_t unit_i,
    sb_issue_if.ctrl  bus,
    input  logic      mul_raw_hazard_i,
    input  logic      mul_lat_hazard_i,
    input  logic      mul_busy_i,
    input  logic      div_raw_hazard_i,
    input  logic      div_lat_hazard_i,
    input  logic      div_struct_hazard_i,
    input  logic      div_busy_i,
    output logic      issue_o,
    output logic      pipeline_empty_o
);

    // Requested latencies include the bypass stage
    localparam lat_t ALU_REQ = lat_t'(`SB_ALU_LATENCY + `SB_BYPASS_CYCLES);
    localparam lat_t MUL_REQ = lat_t'(`SB_MUL_LATENCY + `SB_BYPASS_CYCLES);
    localparam lat_t DIV_REQ = lat_t'(`SB_DIV_LATENCY + `SB_BYPASS_CYCLES);

    logic raw_hazard;
    logic lat_hazard;
    logic struct_hazard;

    // ==========================================================
    // Latency decode
    // ==========================================================

    always_comb begin
        if (unit_i[UNIT_MUL]) begin
            bus.req_latency = MUL_REQ;
        end else if (unit_i[UNIT_DIV]) begin
            bus.req_latency = DIV_REQ;
        end else if (unit_i[UNIT_ALU]) begin
            bus.req_latency = ALU_REQ;
        end else begin
            // No unit, matches no live count
            bus.req_latency = '1;
        end
    end

    assign raw_hazard    = mul_raw_hazard_i | div_raw_hazard_i;
    assign lat_hazard    = mul_lat_hazard_i | div_lat_hazard_i;
    assign struct_hazard = div_struct_hazard_i;

    // Same-cycle grant, trackers see it through the bus
    assign bus.issue = !(raw_hazard | lat_hazard | struct_hazard);
    assign issue_o   = bus.issue;

    // Nothing left in flight
    assign pipeline_empty_o = !(mul_busy_i | div_busy_i);

endmodule : sb_issue_ctrl

`default_nettype wire

// File: src/sb_div_fsm.sv
// Divider occupancy tracking
// The divider is not pipelined, so a single slot plus a busy FSM
// covers it and a second DIV waits for the first to retire

`timescale 1ns/1ps
`default_nettype none

`include "sb_config.svh"

module sb_div_fsm import sb_pkg::*; (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic flush_i,
    input  logic div_req_i,
    sb_issue_if.tracker bus,
    output logic raw_hazard_o,
    output logic lat_hazard_o,
    output logic struct_hazard_o,
    output logic busy_o
);

    div_state_t state_q;
    div_state_t state_d;
    logic       slot_busy;
    lat_t       slot_rem;

    sb_slot_tracker #(
        .LOAD_LATENCY (`SB_DIV_LATENCY)
    ) u_slot (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .load_i       (div_req_i && bus.issue),
        .bus          (bus),
        .raw_hazard_o (raw_hazard_o),
        .lat_hazard_o (lat_hazard_o),
        .busy_o       (slot_busy),
        .remaining_o  (slot_rem)
    );

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            DIV_IDLE: if (div_req_i && bus.issue && !bus.stall) state_d = DIV_BUSY;
            // Last unstalled edge before the quotient is written back
            DIV_BUSY: if (!bus.stall && (slot_rem == lat_t'(1))) state_d = DIV_IDLE;
            default:  state_d = DIV_IDLE;
        endcase
        if (flush_i) begin
            state_d = DIV_IDLE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= DIV_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign busy_o          = (state_q == DIV_BUSY);
    assign struct_hazard_o = div_req_i && busy_o;

    a_state_matches_slot : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        busy_o == slot_busy);

endmodule : sb_div_fsm

`default_nettype wire

// File: src/sb_mul_tracker.sv
// Multiplier result tracking
// One slot per pipeline stage, a rotating one-hot selector picks
// the slot that takes the next accepted MUL

`timescale 1ns/1ps
`default_nettype none

`include "sb_config.svh"

module sb_mul_tracker import sb_pkg::*; #(
    parameter int unsigned NUM_SLOTS = `SB_MUL_LATENCY
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic flush_i,
    input  logic mul_req_i,
    sb_issue_if.tracker bus,
    output logic raw_hazard_o,
    output logic lat_hazard_o,
    output logic busy_o
);

    logic [NUM_SLOTS-1:0] stage_q;
    logic [NUM_SLOTS-1:0] slot_raw;
    logic [NUM_SLOTS-1:0] slot_lat;
    logic [NUM_SLOTS-1:0] slot_busy;

    // ==========================================================
    // Stage selector
    // ==========================================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            stage_q <= NUM_SLOTS'(1);
        end else if (mul_req_i && bus.issue && !bus.stall) begin
            // Rotate left, wrapping at the last stage
            stage_q <= {stage_q[NUM_SLOTS-2:0], stage_q[NUM_SLOTS-1]};
        end
    end

    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
        sb_slot_tracker #(
            .LOAD_LATENCY (`SB_MUL_LATENCY)
        ) u_slot (
            .clk_i        (clk_i),
            .rst_n_i      (rst_n_i),
            .flush_i      (flush_i),
            .load_i       (mul_req_i && bus.issue && stage_q[i]),
            .bus          (bus),
            .raw_hazard_o (slot_raw[i]),
            .lat_hazard_o (slot_lat[i]),
            .busy_o       (slot_busy[i]),
            .remaining_o  ()
        );
    end

    assign raw_hazard_o = |slot_raw;
    assign lat_hazard_o = |slot_lat;
    assign busy_o       = |slot_busy;

    a_stage_onehot : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot(stage_q));

endmodule : sb_mul_tracker

`default_nettype wire

// File: src/sb_slot_tracker.sv
// Single in-flight result slot
// Countdown of the cycles left until write-back plus the destination
// register, with RAW/WAW and write-back collision compares

`timescale 1ns/1ps
`default_nettype none

`include "sb_config.svh"

module sb_slot_tracker import sb_pkg::*; #(
    parameter int unsigned LOAD_LATENCY = `SB_MUL_LATENCY
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic flush_i,
    input  logic load_i,
    sb_issue_if.tracker bus,
    output logic raw_hazard_o,
    output logic lat_hazard_o,
    output logic busy_o,
    output lat_t remaining_o
);

    localparam lat_t LOAD_VAL = lat_t'(LOAD_LATENCY);

    lat_t      count_q;
    reg_addr_t dest_q;
    logic      dest_valid;

    // Countdown, frozen while stalled
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (flush_i) begin
            count_q <= '0;
        end else if (!bus.stall) begin
            if (load_i) begin
                count_q <= LOAD_VAL;
            end else if (busy_o) begin
                count_q <= count_q - lat_t'(1);
            end
        end
    end

    // Destination captured with the load
    always_ff @(posedge clk_i) begin
        if (load_i && !bus.stall) begin
            dest_q <= bus.dest;
        end
    end

    assign busy_o      = (count_q != '0);
    assign remaining_o = count_q;

    // x0 writes never conflict with anything
    assign dest_valid = busy_o && (dest_q != '0);

    assign raw_hazard_o = dest_valid &&
                          ((bus.src_a == dest_q) || (bus.src_b == dest_q) ||
                           (bus.dest == dest_q));

    // New result would land in the same cycle as this one
    assign lat_hazard_o = dest_valid && (bus.req_latency == count_q);

    a_count_bound : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        count_q <= LOAD_VAL);

    // A reload only lands on a slot that is free or retiring at this edge
    a_no_overwrite : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (load_i && !bus.stall && !flush_i) |-> (count_q <= lat_t'(1)));

endmodule : sb_slot_tracker

`default_nettype wire

// File: src/sb_issue_if.sv
// Scoreboard issue bus
// Dispatched instruction and the issue grant, shared by the
// issue control and the result trackers

`timescale 1ns/1ps
`default_nettype none

interface sb_issue_if import sb_pkg::*; ();

    // Dispatched instruction, driven from the top level
    reg_addr_t src_a;
    reg_addr_t src_b;
    reg_addr_t dest;
    logic      stall;

    // Decoded by the issue control
    lat_t      req_latency;
    logic      issue;

    // Latency decode and grant
    modport ctrl (
        input  src_a, src_b, dest, stall,
        output req_latency, issue
    );

    // Hazard compares and slot loading
    modport tracker (
        input  src_a, src_b, dest, stall, req_latency, issue
    );

endinterface : sb_issue_if

`default_nettype wire

// File: src/sb_pkg.sv
// Issue scoreboard types
// Register address, latency count, unit selection and divider state

`default_nettype none

`include "sb_config.svh"

package sb_pkg;

    // Register address, zero is the hard-wired zero register
    typedef logic [`SB_REG_ADDR_W-1:0] reg_addr_t;

    // Latency or remaining-cycle count
    typedef logic [`SB_LAT_W-1:0] lat_t;

    // One-hot unit selection
    typedef logic [2:0] unit_sel_t;

    // Bit positions inside unit_sel_t
    localparam int UNIT_ALU = 0;
    localparam int UNIT_MUL = 1;
    localparam int UNIT_DIV = 2;

    // Divider occupancy
    typedef enum logic [0:0] {
        DIV_IDLE,
        DIV_BUSY
    } div_state_t;

endpackage : sb_pkg

`default_nettype wire

// File: src/sb_config.svh
// Issue scoreboard configuration
// Register address width, counter width and unit latencies

`ifndef SB_CONFIG_SVH
`define SB_CONFIG_SVH

// Width of a register file address
`define SB_REG_ADDR_W 5

// Width of latency and countdown values, must hold DIV latency + bypass
`define SB_LAT_W 6

// ALU and CSR results are ready one cycle after execute
`define SB_ALU_LATENCY 1

// Pipelined multiplier, one tracking slot per stage
`define SB_MUL_LATENCY 6

// Sequential divider
`define SB_DIV_LATENCY 36

// Bypass stage sits in front of execute
`define SB_BYPASS_CYCLES 1

`endif
